//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = tb_mem_port
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- list.f
src/arb_pkg.sv
src/lsu_arbiter.sv
src/arb_csr.sv
src/mem_port_top.sv
test/tb_mem_port.sv

//--- src/arb_csr.sv
`timescale 1ns/10ps
`default_nettype none

module arb_csr import arb_pkg::*; #(
    parameter logic [7:0] RESET_TIMEOUT = 8'd10
) (
    input  wire         clk,
    input  wire         rst_n,

    input  wire         cfg_we_i,
    input  wire  [1:0]  cfg_addr_i,
    input  wire  [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,

    output arb_cfg_t    cfg_o,
    input  arb_event_t  event_i
);

    localparam int NCNT = 3;

    arb_cfg_t        ctrl_q;
    logic [15:0]     cnt_q [NCNT];  // 0 igrant, 1 dgrant, 2 timeout
    logic [NCNT-1:0] cnt_inc;
    logic [NCNT-1:0] cnt_clr;
    logic            wr_ctrl;
    logic            wr_grants;
    logic            wr_timeouts;

    assign wr_ctrl     = cfg_we_i & (cfg_addr_i == CSR_CTRL);
    assign wr_grants   = cfg_we_i & (cfg_addr_i == CSR_GRANTS);
    assign wr_timeouts = cfg_we_i & (cfg_addr_i == CSR_TIMEOUTS);

    assign cnt_inc = {event_i.timeout, event_i.dgrant, event_i.igrant};
    assign cnt_clr = {wr_timeouts, wr_grants, wr_grants};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q.dcache_first  <= 1'b0;
            ctrl_q.grant_timeout <= RESET_TIMEOUT;
        end else if (wr_ctrl) begin
            ctrl_q.dcache_first  <= cfg_wdata_i[0];
            ctrl_q.grant_timeout <= cfg_wdata_i[15:8];
        end
    end

    // Saturating event counters that a write clears
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NCNT; i++) begin
                cnt_q[i] <= 16'd0;
            end
        end else begin
            for (int i = 0; i < NCNT; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= 16'd0;
                end else if (cnt_inc[i] && cnt_q[i] != 16'hffff) begin
                    cnt_q[i] <= cnt_q[i] + 16'd1;
                end
            end
        end
    end

    assign cfg_o = ctrl_q;

    always_comb begin
        case (cfg_addr_i)
            CSR_CTRL: begin
                cfg_rdata_o = {16'd0, ctrl_q.grant_timeout, 7'd0, ctrl_q.dcache_first};
            end
            CSR_GRANTS: begin
                cfg_rdata_o = {cnt_q[1], cnt_q[0]};
            end
            CSR_TIMEOUTS: begin
                cfg_rdata_o = {16'd0, cnt_q[2]};
            end
            default: cfg_rdata_o = 32'd0;  // Unmapped
        endcase
    end

endmodule

`default_nettype wire

//--- src/arb_pkg.sv
`default_nettype none

package arb_pkg;

    // One memory access as issued by a requester
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } mem_req_t;

    // Read response that also closes a write
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       dcache_first;  // Data side wins ties
        logic [7:0] grant_timeout;
    } arb_cfg_t;

    // Single-cycle pulses from the arbiter
    typedef struct packed {
        logic igrant;
        logic dgrant;
        logic timeout;
    } arb_event_t;

    // Register map
    localparam logic [1:0] CSR_CTRL     = 2'd0;
    localparam logic [1:0] CSR_GRANTS   = 2'd1;
    localparam logic [1:0] CSR_TIMEOUTS = 2'd2;

endpackage

`default_nettype wire

//--- src/lsu_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_arbiter import arb_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,

    // Instruction side
    input  wire        ireq_i,
    input  mem_req_t   ireq_data_i,
    output logic       igrant_o,
    output logic       ierr_o,
    output mem_rsp_t   irsp_o,

    // Data side
    input  wire        dreq_i,
    input  mem_req_t   dreq_data_i,
    output logic       dgrant_o,
    output logic       derr_o,
    output mem_rsp_t   drsp_o,

    // Memory port
    output logic       mem_req_o,
    output mem_req_t   mem_data_o,
    input  wire        mem_gnt_i,
    input  mem_rsp_t   mem_rsp_i,

    // Configuration and events
    input  arb_cfg_t   cfg_i,
    output arb_event_t event_o
);

    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        GRANT_WAIT = 2'b01,
        DATA_WAIT  = 2'b10
    } state_t;

    state_t     state_q;
    state_t     state_d;
    logic       owner_d_q;  // High when the data side owns the transaction
    logic       pick_d;
    logic       any_req;
    logic [7:0] wait_cnt_q;
    logic       grant_hit;
    logic       timeout_hit;
    logic       rsp_hit;
    mem_req_t   req_q;

    assign any_req = ireq_i | dreq_i;

    // Data side wins if alone, or on a tie when it is preferred
    assign pick_d = dreq_i & (cfg_i.dcache_first | ~ireq_i);

    assign grant_hit   = (state_q == GRANT_WAIT) & mem_gnt_i;
    assign timeout_hit = (state_q == GRANT_WAIT) & ~mem_gnt_i &
                         (wait_cnt_q >= cfg_i.grant_timeout);
    assign rsp_hit     = (state_q == DATA_WAIT) & mem_rsp_i.rvalid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (any_req) begin
                    state_d = GRANT_WAIT;
                end
            end
            GRANT_WAIT: begin
                if (grant_hit) begin
                    state_d = DATA_WAIT;
                end else if (timeout_hit) begin
                    state_d = IDLE;
                end
            end
            DATA_WAIT: begin
                if (rsp_hit) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            owner_d_q  <= 1'b0;
            wait_cnt_q <= 8'd0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                wait_cnt_q <= 8'd0;
                if (any_req) begin
                    owner_d_q <= pick_d;
                end
            end else if (state_q == GRANT_WAIT && !grant_hit) begin
                wait_cnt_q <= wait_cnt_q + 8'd1;
            end
        end
    end

    // Request payload held until grant or timeout
    always_ff @(posedge clk) begin
        if (state_q == IDLE && any_req) begin
            req_q <= pick_d ? dreq_data_i : ireq_data_i;
        end
    end

    assign mem_req_o  = (state_q == GRANT_WAIT);
    assign mem_data_o = req_q;

    // Pulses go to the owner only
    assign igrant_o = grant_hit & ~owner_d_q;
    assign dgrant_o = grant_hit & owner_d_q;
    assign ierr_o   = timeout_hit & ~owner_d_q;
    assign derr_o   = timeout_hit & owner_d_q;

    always_comb begin
        irsp_o        = mem_rsp_i;
        drsp_o        = mem_rsp_i;
        irsp_o.rvalid = rsp_hit & ~owner_d_q;
        drsp_o.rvalid = rsp_hit & owner_d_q;
    end

    assign event_o.igrant  = igrant_o;
    assign event_o.dgrant  = dgrant_o;
    assign event_o.timeout = timeout_hit;

endmodule

`default_nettype wire

//--- src/mem_port_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_port_top import arb_pkg::*; #(
    parameter logic [7:0] RESET_TIMEOUT = 8'd10
) (
    input  wire         clk,
    input  wire         rst_n,

    // Instruction requester
    input  wire         ireq_i,
    input  mem_req_t    ireq_data_i,
    output logic        igrant_o,
    output logic        ierr_o,
    output mem_rsp_t    irsp_o,

    // Data requester
    input  wire         dreq_i,
    input  mem_req_t    dreq_data_i,
    output logic        dgrant_o,
    output logic        derr_o,
    output mem_rsp_t    drsp_o,

    // External memory
    output logic        mem_req_o,
    output logic [31:0] mem_addr_o,
    output logic        mem_we_o,
    output logic [3:0]  mem_be_o,
    output logic [31:0] mem_wdata_o,
    input  wire         mem_gnt_i,
    input  wire         mem_rvalid_i,
    input  wire  [31:0] mem_rdata_i,

    // Configuration
    input  wire         cfg_we_i,
    input  wire  [1:0]  cfg_addr_i,
    input  wire  [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o
);

    mem_req_t   mem_data;
    mem_rsp_t   mem_rsp;
    arb_cfg_t   arb_cfg;
    arb_event_t arb_events;

    assign mem_addr_o  = mem_data.addr;
    assign mem_we_o    = mem_data.we;
    assign mem_be_o    = mem_data.be;
    assign mem_wdata_o = mem_data.wdata;

    assign mem_rsp.rvalid = mem_rvalid_i;
    assign mem_rsp.rdata  = mem_rdata_i;

    lsu_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .ireq_i      (ireq_i),
        .ireq_data_i (ireq_data_i),
        .igrant_o    (igrant_o),
        .ierr_o      (ierr_o),
        .irsp_o      (irsp_o),
        .dreq_i      (dreq_i),
        .dreq_data_i (dreq_data_i),
        .dgrant_o    (dgrant_o),
        .derr_o      (derr_o),
        .drsp_o      (drsp_o),
        .mem_req_o   (mem_req_o),
        .mem_data_o  (mem_data),
        .mem_gnt_i   (mem_gnt_i),
        .mem_rsp_i   (mem_rsp),
        .cfg_i       (arb_cfg),
        .event_o     (arb_events)
    );

    arb_csr #(
        .RESET_TIMEOUT (RESET_TIMEOUT)
    ) u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_o       (arb_cfg),
        .event_i     (arb_events)
    );

endmodule

`default_nettype wire

//--- test/tb_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_port import arb_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        ireq;
    logic        dreq;
    mem_req_t    ireq_data;
    mem_req_t    dreq_data;
    logic        igrant;
    logic        ierr;
    logic        dgrant;
    logic        derr;
    mem_rsp_t    irsp;
    mem_rsp_t    drsp;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [3:0]  mem_be;
    logic [31:0] mem_wdata;
    logic        mem_gnt;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        cfg_we;
    logic [1:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;

    logic [31:0] rng;
    int          errors;
    logic [31:0] ram [256];      // Memory behind the port
    logic [31:0] exp_mem [256];  // What the requesters expect to read
    mem_req_t    i_held;
    mem_req_t    d_held;
    mem_req_t    cur_req;
    int          i_state;        // 0 done, 1 requesting, 2 waiting for rvalid
    int          d_state;
    int          phase;          // Arbiter model state 0 idle, 1 grant wait, 2 data wait
    bit          owner_d;
    int          wcnt;
    int          cur_to;
    bit          dfirst;
    int          cnt_ig;
    int          cnt_dg;
    int          cnt_to;
    bit          resp_active;
    int          req_cnt;
    int          gdelay;
    bit          rv_pend;
    int          rv_wait;
    logic [7:0]  rv_idx;
    int          first_pulse;    // 1 instruction side, 2 data side
    bit          aborted;

    mem_port_top dut_i (
        .clk (clk), .rst_n (rst_n),
        .ireq_i (ireq), .ireq_data_i (ireq_data),
        .igrant_o (igrant), .ierr_o (ierr), .irsp_o (irsp),
        .dreq_i (dreq), .dreq_data_i (dreq_data),
        .dgrant_o (dgrant), .derr_o (derr), .drsp_o (drsp),
        .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_we_o (mem_we),
        .mem_be_o (mem_be), .mem_wdata_o (mem_wdata), .mem_gnt_i (mem_gnt),
        .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata),
        .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng = x;
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic make_request(output mem_req_t r);
        logic [31:0] a;
        a = next_rand();
        r.addr  = {a[31:10], 4'd0, a[3:0], 2'b00};  // 16 words so addresses repeat
        r.we    = a[4];
        r.be    = r.we ? (a[8:5] | 4'h1) : 4'hf;
        r.wdata = next_rand();
    endtask

    // One clock cycle of memory responder, checks and model updates
    task automatic run_cycle();
        logic     gnt;
        logic     rv;
        logic     e_grant;
        logic     e_err;
        logic     e_rv;
        mem_req_t own;
        logic [7:0] idx;
        if (!mem_req) begin
            resp_active = 0;
        end else if (!resp_active) begin
            resp_active = 1;
            req_cnt     = 0;
            gdelay      = next_rand() % 15;
        end
        gnt = mem_req && (req_cnt == gdelay);
        rv  = 1'b0;
        if (rv_pend) begin
            rv_wait--;
            if (rv_wait == 0) begin
                rv      = 1'b1;
                rv_pend = 0;
            end
        end
        mem_gnt    = gnt;
        mem_rvalid = rv;
        mem_rdata  = rv ? ram[rv_idx] : next_rand();
        #1;
        own     = owner_d ? d_held : i_held;
        e_grant = (phase == 1) && gnt;
        e_err   = (phase == 1) && !gnt && (wcnt >= cur_to);
        e_rv    = (phase == 2) && rv;

        if (mem_req !== (phase == 1)) report_mismatch("mem_req_o", phase == 1, mem_req);
        if (phase == 1) begin
            if (mem_addr !== own.addr) report_mismatch("mem_addr_o", own.addr, mem_addr);
            if (mem_we !== own.we) report_mismatch("mem_we_o", own.we, mem_we);
            if (mem_be !== own.be) report_mismatch("mem_be_o", own.be, mem_be);
            if (mem_wdata !== own.wdata) report_mismatch("mem_wdata_o", own.wdata, mem_wdata);
        end
        if (igrant !== (e_grant && !owner_d)) begin
            report_mismatch("igrant_o", e_grant && !owner_d, igrant);
        end
        if (dgrant !== (e_grant && owner_d)) begin
            report_mismatch("dgrant_o", e_grant && owner_d, dgrant);
        end
        if (ierr !== (e_err && !owner_d)) begin
            report_mismatch("ierr_o", e_err && !owner_d, ierr);
        end
        if (derr !== (e_err && owner_d)) begin
            report_mismatch("derr_o", e_err && owner_d, derr);
        end
        if (irsp.rvalid !== (e_rv && !owner_d)) begin
            report_mismatch("irsp_o.rvalid", e_rv && !owner_d, irsp.rvalid);
        end
        if (drsp.rvalid !== (e_rv && owner_d)) begin
            report_mismatch("drsp_o.rvalid", e_rv && owner_d, drsp.rvalid);
        end
        if (e_rv && !cur_req.we) begin
            idx = cur_req.addr[9:2];
            if (!owner_d && irsp.rdata !== exp_mem[idx]) begin
                report_mismatch("irsp_o.rdata", exp_mem[idx], irsp.rdata);
            end
            if (owner_d && drsp.rdata !== exp_mem[idx]) begin
                report_mismatch("drsp_o.rdata", exp_mem[idx], drsp.rdata);
            end
        end
        if (e_err && req_cnt != cur_to) begin
            errors++;
            $display("memory request lasted %0d cycles before the error, expected %0d",
                     req_cnt + 1, cur_to + 1);
        end
        if (first_pulse == 0 && (igrant || ierr)) first_pulse = 1;
        if (first_pulse == 0 && (dgrant || derr)) first_pulse = 2;

        // Memory acts on its own grant
        if (gnt) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_we && mem_be[b]) ram[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
            end
            rv_pend = 1;
            rv_wait = 1 + next_rand() % 4;
            rv_idx  = mem_addr[9:2];
        end
        if (e_grant) begin
            cur_req = own;
            idx     = own.addr[9:2];
            for (int b = 0; b < 4; b++) begin
                if (own.we && own.be[b]) exp_mem[idx][8*b +: 8] = own.wdata[8*b +: 8];
            end
            if (owner_d) begin
                d_state = 2;
                cnt_dg++;
            end else begin
                i_state = 2;
                cnt_ig++;
            end
        end else if (mem_req) begin
            req_cnt++;
        end
        if (e_err) begin
            cnt_to++;
            if (owner_d) d_state = 0;
            else i_state = 0;
        end
        if (e_rv) begin
            if (owner_d) d_state = 0;
            else i_state = 0;
        end

        case (phase)
            0: if (ireq || dreq) begin
                owner_d = dreq && (dfirst || !ireq);
                phase   = 1;
                wcnt    = 0;
            end
            1: begin
                if (e_grant) phase = 2;
                else if (e_err) phase = 0;
                else wcnt++;
            end
            default: if (e_rv) phase = 0;
        endcase

        @(negedge clk);
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        ireq       = (i_state == 1);  // Requesters drop req after gnt or err
        dreq       = (d_state == 1);
    endtask

    // Sides 0 instruction only, 1 data only, 2 both
    task automatic run_txn(input int sides);
        int n;
        make_request(i_held);
        make_request(d_held);
        i_state     = (sides != 1) ? 1 : 0;
        d_state     = (sides != 0) ? 1 : 0;
        ireq_data   = i_held;
        dreq_data   = d_held;
        ireq        = (i_state == 1);
        dreq        = (d_state == 1);
        first_pulse = 0;
        n = 0;
        while ((i_state != 0 || d_state != 0 || phase != 0) && n < 200) begin
            run_cycle();
            n++;
        end
        if (n >= 200) begin
            errors++;
            aborted = 1;
            $display("transaction did not finish within 200 cycles");
        end
    endtask

    task automatic csr_write(input logic [1:0] addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
        if (addr == CSR_CTRL) begin
            dfirst = data[0];
            cur_to = data[15:8];
        end
        if (addr == CSR_GRANTS) begin
            cnt_ig = 0;
            cnt_dg = 0;
        end
        if (addr == CSR_TIMEOUTS) cnt_to = 0;
    endtask

    task automatic csr_check(input logic [1:0] addr, input logic [31:0] exp,
                             input string name);
        cfg_addr = addr;
        #1;
        if (cfg_rdata !== exp) report_mismatch(name, exp, cfg_rdata);
        @(negedge clk);
    endtask

    task automatic check_quiet();
        if (mem_req || igrant || ierr || dgrant || derr || irsp.rvalid || drsp.rvalid) begin
            errors++;
            $display("outputs not low at %0t during or right after reset", $time);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        ireq = 1'b0;
        dreq = 1'b0;
        ireq_data = '0;
        dreq_data = '0;
        mem_gnt = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        cfg_we = 1'b0;
        cfg_addr = CSR_CTRL;
        cfg_wdata = '0;
        rng = 32'd94642;
        errors = 0;
        phase = 0;
        owner_d = 0;
        cur_to = 10;
        dfirst = 0;
        cnt_ig = 0;
        cnt_dg = 0;
        cnt_to = 0;
        resp_active = 0;
        rv_pend = 0;
        aborted = 0;
        for (int i = 0; i < 256; i++) begin
            ram[i]     = i * 32'h9e3779b1 + 32'h00012345;
            exp_mem[i] = ram[i];
        end

        repeat (10) begin
            @(negedge clk);
            check_quiet();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet();
        csr_check(CSR_CTRL, 32'h00000a00, "cfg_rdata_o CTRL after reset");

        run_txn(2);
        if (first_pulse != 1) begin
            errors++;
            $display("instruction side did not win the tie with reset priority");
        end
        csr_write(CSR_CTRL, 32'h00000a01);
        run_txn(2);
        if (first_pulse != 2) begin
            errors++;
            $display("data side did not win the tie with dcache_first set");
        end
        for (int k = 0; k < 60 && !aborted; k++) run_txn(next_rand() % 3);
        csr_check(CSR_GRANTS, {cnt_dg[15:0], cnt_ig[15:0]}, "cfg_rdata_o GRANTS");
        csr_check(CSR_TIMEOUTS, {16'd0, cnt_to[15:0]}, "cfg_rdata_o TIMEOUTS");

        csr_write(CSR_GRANTS, 32'hffffffff);
        csr_write(CSR_TIMEOUTS, 32'hffffffff);
        csr_check(CSR_GRANTS, 32'd0, "cfg_rdata_o GRANTS after clear");
        csr_check(CSR_TIMEOUTS, 32'd0, "cfg_rdata_o TIMEOUTS after clear");

        csr_write(CSR_CTRL, 32'h00000300);  // Short timeout, instruction side first
        for (int k = 0; k < 40 && !aborted; k++) run_txn(next_rand() % 3);
        csr_check(CSR_GRANTS, {cnt_dg[15:0], cnt_ig[15:0]}, "cfg_rdata_o GRANTS");
        csr_check(CSR_TIMEOUTS, {16'd0, cnt_to[15:0]}, "cfg_rdata_o TIMEOUTS");

        $display("errors: %0d, grants i/d: %0d/%0d, timeouts: %0d",
                 errors, cnt_ig, cnt_dg, cnt_to);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
